// File: rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN         = 32;
    localparam int OPCODE_WIDTH = 7;
    localparam int FUNCT3_WIDTH = 3;
    localparam int FUNCT7_WIDTH = 7;
    localparam int NR_OPCODES   = 10;  // Opcodes that map to a known format

    localparam logic [OPCODE_WIDTH-1:0] OP_LUI    = 7'b0110111;
    localparam logic [OPCODE_WIDTH-1:0] OP_AUIPC  = 7'b0010111;
    localparam logic [OPCODE_WIDTH-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OPCODE_WIDTH-1:0] OP_JALR   = 7'b1100111;
    localparam logic [OPCODE_WIDTH-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_WIDTH-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_WIDTH-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_WIDTH-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_WIDTH-1:0] OP_REG    = 7'b0110011;
    localparam logic [OPCODE_WIDTH-1:0] OP_SYSTEM = 7'b1110011;  // Also carries the Zicsr ops

    typedef enum logic [2:0] {
        TYPE_N = 3'd0,  // Opcode not recognised
        TYPE_R = 3'd1,
        TYPE_I = 3'd2,
        TYPE_S = 3'd3,
        TYPE_B = 3'd4,
        TYPE_U = 3'd5,
        TYPE_J = 3'd6
    } inst_type_t;

    // Low two bits of funct3 on a SYSTEM instruction; bit 2 picks the zimm form
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'b00,
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_t;

endpackage

`default_nettype wire

// File: rtl/rv_csr_pkg.sv
`default_nettype none

package rv_csr_pkg;

    localparam int CSR_ADDR_WIDTH = 12;

    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MTVEC   = 12'h305;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MEPC    = 12'h341;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MCAUSE  = 12'h342;

    localparam logic [rv_isa_pkg::XLEN-1:0] MSTATUS_RESET = 32'h0000_1800;  // MPP is machine
    localparam logic [rv_isa_pkg::XLEN-1:0] MTVEC_RESET   = '0;
    localparam logic [rv_isa_pkg::XLEN-1:0] MEPC_RESET    = '0;
    localparam logic [rv_isa_pkg::XLEN-1:0] MCAUSE_RESET  = '0;

endpackage

`default_nettype wire

// File: rtl/key_lut.sv
`default_nettype none

module key_lut #(
    parameter int  NR_KEY = 2,
    parameter type key_t  = logic [3:0],
    parameter type data_t = logic [7:0]
) (
    input  key_t                                           key,
    input  data_t                                          default_out,
    input  logic [NR_KEY*($bits(key_t)+$bits(data_t))-1:0] lut,
    output data_t                                          data
);

    localparam int KEY_W  = $bits(key_t);
    localparam int DATA_W = $bits(data_t);
    localparam int PAIR_W = KEY_W + DATA_W;

    logic [KEY_W-1:0]  pair_key  [NR_KEY];
    logic [DATA_W-1:0] pair_data [NR_KEY];

    // Pair 0 is the leftmost entry of the concatenation, key above data
    for (genvar i = 0; i < NR_KEY; i++) begin : g_pair
        assign pair_key[i]  = lut[(NR_KEY-i)*PAIR_W-1 -: KEY_W];
        assign pair_data[i] = lut[(NR_KEY-i)*PAIR_W-KEY_W-1 -: DATA_W];
    end

    always_comb begin
        data = default_out;
        for (int i = NR_KEY - 1; i >= 0; i--) begin  // Walk down so the first listed pair wins
            if (pair_key[i] == key) begin
                data = data_t'(pair_data[i]);
            end
        end
    end

    always_comb begin
        if (!$isunknown(key)) begin
            assert final (!$isunknown(data))
                else $error("key_lut: unknown data for key %0h", key);
        end
    end

endmodule

`default_nettype wire

// File: rtl/gpr_file.sv
`default_nettype none

module gpr_file #(
    parameter  int NR_REGS = 32,
    localparam int ADDR_W  = $clog2(NR_REGS)
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [ADDR_W-1:0]           w_addr,
    input  logic [rv_isa_pkg::XLEN-1:0] w_data,
    input  logic                        w_en,
    input  logic [ADDR_W-1:0]           r1_addr,
    input  logic [ADDR_W-1:0]           r2_addr,
    output logic [rv_isa_pkg::XLEN-1:0] r1_data,
    output logic [rv_isa_pkg::XLEN-1:0] r2_data
);

    logic [rv_isa_pkg::XLEN-1:0] regs [1:NR_REGS-1];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NR_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en && (w_addr != '0)) begin
            regs[w_addr] <= w_data;
        end
    end

    // Both ports are plain muxes, a write shows up from the next cycle on
    always_comb begin
        r1_data = '0;
        if (r1_addr != '0) begin
            r1_data = regs[r1_addr];
        end
    end

    always_comb begin
        r2_data = '0;
        if (r2_addr != '0) begin
            r2_data = regs[r2_addr];
        end
    end

    a_w_addr_known: assert property (
        @(posedge clk) disable iff (rst)
        w_en |-> !$isunknown(w_addr)
    ) else $error("gpr_file: write strobe with unknown address");

endmodule

`default_nettype wire

// File: rtl/csr_file.sv
`default_nettype none

module csr_file (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [rv_csr_pkg::CSR_ADDR_WIDTH-1:0] addr,
    input  logic [rv_isa_pkg::XLEN-1:0]         w_data,
    input  logic                                w_en,
    input  logic [rv_isa_pkg::XLEN-1:0]         pc,
    input  logic [rv_isa_pkg::XLEN-1:0]         intr_code,
    input  logic                                is_intr,
    output logic [rv_isa_pkg::XLEN-1:0]         r_data,
    output logic [rv_isa_pkg::XLEN-1:0]         mepc,
    output logic [rv_isa_pkg::XLEN-1:0]         mtvec
);

    logic [rv_isa_pkg::XLEN-1:0] mstatus;
    logic [rv_isa_pkg::XLEN-1:0] mcause;

    logic wr_mstatus;
    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;

    // An address outside the four known CSRs selects nothing and the write is dropped
    assign wr_mstatus = w_en && (addr == rv_csr_pkg::CSR_MSTATUS);
    assign wr_mtvec   = w_en && (addr == rv_csr_pkg::CSR_MTVEC);
    assign wr_mepc    = w_en && (addr == rv_csr_pkg::CSR_MEPC);
    assign wr_mcause  = w_en && (addr == rv_csr_pkg::CSR_MCAUSE);

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= rv_csr_pkg::MSTATUS_RESET;
            mtvec   <= rv_csr_pkg::MTVEC_RESET;
        end else begin
            if (wr_mstatus) begin
                mstatus <= w_data;
            end
            if (wr_mtvec) begin
                mtvec <= w_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc   <= rv_csr_pkg::MEPC_RESET;
            mcause <= rv_csr_pkg::MCAUSE_RESET;
        end else if (is_intr) begin
            mepc   <= pc;  // Trap entry overrides a CSR write in the same cycle
            mcause <= intr_code;
        end else begin
            if (wr_mepc) begin
                mepc <= w_data;
            end
            if (wr_mcause) begin
                mcause <= w_data;
            end
        end
    end

    always_comb begin
        case (addr)
            rv_csr_pkg::CSR_MSTATUS: r_data = mstatus;
            rv_csr_pkg::CSR_MTVEC:   r_data = mtvec;
            rv_csr_pkg::CSR_MEPC:    r_data = mepc;
            rv_csr_pkg::CSR_MCAUSE:  r_data = mcause;
            default:                 r_data = '0;
        endcase
    end

    // Fetch only produces word-aligned addresses without the C extension
    a_trap_pc_aligned: assert property (
        @(posedge clk) disable iff (rst)
        is_intr |-> (pc[1:0] == 2'b00)
    ) else $error("csr_file: trap taken with misaligned pc %08h", pc);

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`default_nettype none

module decode_stage #(
    parameter  int NR_REGS = 32,
    localparam int ADDR_W  = $clog2(NR_REGS)
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [rv_isa_pkg::XLEN-1:0]           inst,
    output rv_isa_pkg::inst_type_t                inst_type,
    output logic [rv_isa_pkg::XLEN-1:0]           imm,
    output logic [rv_isa_pkg::OPCODE_WIDTH-1:0]   opcode,
    output logic [rv_isa_pkg::FUNCT3_WIDTH-1:0]   funct3,
    output logic [rv_isa_pkg::FUNCT7_WIDTH-1:0]   funct7,
    input  logic [rv_isa_pkg::XLEN-1:0]           srd,
    output logic [rv_isa_pkg::XLEN-1:0]           src1,
    output logic [rv_isa_pkg::XLEN-1:0]           src2,
    input  logic                                  gpr_w_en,
    input  logic                                  is_csri,
    input  logic [rv_isa_pkg::XLEN-1:0]           pc,
    output logic [rv_isa_pkg::XLEN-1:0]           mepc,
    output logic [rv_isa_pkg::XLEN-1:0]           mtvec,
    output logic [rv_isa_pkg::XLEN-1:0]           csr_r,
    input  logic [rv_isa_pkg::XLEN-1:0]           intr_code,
    input  logic                                  is_intr,
    input  logic                                  csr_w_en
);

    localparam int XLEN = rv_isa_pkg::XLEN;

    logic [ADDR_W-1:0]                     rd;
    logic [ADDR_W-1:0]                     rs1;
    logic [ADDR_W-1:0]                     rs2;
    logic [rv_csr_pkg::CSR_ADDR_WIDTH-1:0] csr_addr;
    logic [XLEN-1:0]                       imm_i;
    logic [XLEN-1:0]                       imm_s;
    logic [XLEN-1:0]                       imm_b;
    logic [XLEN-1:0]                       imm_u;
    logic [XLEN-1:0]                       imm_j;
    logic [XLEN-1:0]                       zimm;
    logic [XLEN-1:0]                       csr_src;
    logic [XLEN-1:0]                       csr_w;
    rv_isa_pkg::csr_op_t                   csr_op;

    assign opcode = inst[0 +: rv_isa_pkg::OPCODE_WIDTH];
    assign funct3 = inst[12 +: rv_isa_pkg::FUNCT3_WIDTH];
    assign funct7 = inst[25 +: rv_isa_pkg::FUNCT7_WIDTH];

    assign rd       = inst[7 +: ADDR_W];  // RV32E keeps only the low four bits
    assign rs1      = inst[15 +: ADDR_W];
    assign rs2      = inst[20 +: ADDR_W];
    assign csr_addr = inst[20 +: rv_csr_pkg::CSR_ADDR_WIDTH];

    key_lut #(
        .NR_KEY(rv_isa_pkg::NR_OPCODES),
        .key_t (logic [rv_isa_pkg::OPCODE_WIDTH-1:0]),
        .data_t(rv_isa_pkg::inst_type_t)
    ) type_lut_i (
        .key        (opcode),
        .default_out(rv_isa_pkg::TYPE_N),
        .lut        ({
            rv_isa_pkg::OP_LUI,    rv_isa_pkg::TYPE_U,
            rv_isa_pkg::OP_AUIPC,  rv_isa_pkg::TYPE_U,
            rv_isa_pkg::OP_JAL,    rv_isa_pkg::TYPE_J,
            rv_isa_pkg::OP_JALR,   rv_isa_pkg::TYPE_I,
            rv_isa_pkg::OP_BRANCH, rv_isa_pkg::TYPE_B,
            rv_isa_pkg::OP_LOAD,   rv_isa_pkg::TYPE_I,
            rv_isa_pkg::OP_STORE,  rv_isa_pkg::TYPE_S,
            rv_isa_pkg::OP_IMM,    rv_isa_pkg::TYPE_I,
            rv_isa_pkg::OP_REG,    rv_isa_pkg::TYPE_R,
            rv_isa_pkg::OP_SYSTEM, rv_isa_pkg::TYPE_I
        }),
        .data       (inst_type)
    );

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // R and unknown formats carry no immediate and fall to the default
    key_lut #(
        .NR_KEY(5),
        .key_t (rv_isa_pkg::inst_type_t),
        .data_t(logic [XLEN-1:0])
    ) imm_lut_i (
        .key        (inst_type),
        .default_out('0),
        .lut        ({
            rv_isa_pkg::TYPE_I, imm_i,
            rv_isa_pkg::TYPE_S, imm_s,
            rv_isa_pkg::TYPE_B, imm_b,
            rv_isa_pkg::TYPE_U, imm_u,
            rv_isa_pkg::TYPE_J, imm_j
        }),
        .data       (imm)
    );

    gpr_file #(
        .NR_REGS(NR_REGS)
    ) gpr_file_i (
        .clk    (clk),
        .rst    (rst),
        .w_addr (rd),
        .w_data (srd),
        .w_en   (gpr_w_en),
        .r1_addr(rs1),
        .r2_addr(rs2),
        .r1_data(src1),
        .r2_data(src2)
    );

    assign zimm    = {{(XLEN-5){1'b0}}, inst[19:15]};
    assign csr_src = is_csri ? zimm : src1;
    assign csr_op  = rv_isa_pkg::csr_op_t'(funct3[1:0]);

    key_lut #(
        .NR_KEY(3),
        .key_t (rv_isa_pkg::csr_op_t),
        .data_t(logic [XLEN-1:0])
    ) csr_w_lut_i (
        .key        (csr_op),
        .default_out('0),
        .lut        ({
            rv_isa_pkg::CSR_OP_WRITE, csr_src,
            rv_isa_pkg::CSR_OP_SET,   csr_r | csr_src,
            rv_isa_pkg::CSR_OP_CLEAR, csr_r & ~csr_src
        }),
        .data       (csr_w)
    );

    csr_file csr_file_i (
        .clk      (clk),
        .rst      (rst),
        .addr     (csr_addr),
        .w_data   (csr_w),
        .w_en     (csr_w_en),
        .pc       (pc),
        .intr_code(intr_code),
        .is_intr  (is_intr),
        .r_data   (csr_r),
        .mepc     (mepc),
        .mtvec    (mtvec)
    );

endmodule

`default_nettype wire

// File: sim/tb_decode_model.svh
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// Instruction format of each base opcode
function automatic rv_isa_pkg::inst_type_t model_type(input logic [6:0] op);
    case (op)
        rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC: return rv_isa_pkg::TYPE_U;
        rv_isa_pkg::OP_JAL: return rv_isa_pkg::TYPE_J;
        rv_isa_pkg::OP_JALR, rv_isa_pkg::OP_LOAD: return rv_isa_pkg::TYPE_I;
        rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_SYSTEM: return rv_isa_pkg::TYPE_I;
        rv_isa_pkg::OP_BRANCH: return rv_isa_pkg::TYPE_B;
        rv_isa_pkg::OP_STORE: return rv_isa_pkg::TYPE_S;
        rv_isa_pkg::OP_REG: return rv_isa_pkg::TYPE_R;
        default: return rv_isa_pkg::TYPE_N;
    endcase
endfunction

function automatic logic [31:0] model_imm(input logic [31:0] word,
                                          input rv_isa_pkg::inst_type_t fmt);
    logic signed [31:0] s;
    logic [31:0]        hi20;
    logic [31:0]        hi25;
    logic [31:0]        sign;
    s    = word;
    hi20 = s >>> 20;  // Arithmetic shifts give the sign extension
    hi25 = s >>> 25;
    sign = s >>> 31;
    case (fmt)
        rv_isa_pkg::TYPE_I: return hi20;
        rv_isa_pkg::TYPE_S: return (hi25 << 5) | 32'(word[11:7]);
        rv_isa_pkg::TYPE_B: return (sign << 12) | (32'(word[7]) << 11)
                                   | (32'(word[30:25]) << 5) | (32'(word[11:8]) << 1);
        rv_isa_pkg::TYPE_U: return word & 32'hffff_f000;
        rv_isa_pkg::TYPE_J: return (sign << 20) | (32'(word[19:12]) << 12)
                                   | (32'(word[20]) << 11) | (32'(word[30:21]) << 1);
        default: return '0;
    endcase
endfunction

function automatic logic [31:0] model_csr(input logic [31:0] old, input logic [31:0] src,
                                          input rv_isa_pkg::csr_op_t op);
    case (op)
        rv_isa_pkg::CSR_OP_WRITE: return src;
        rv_isa_pkg::CSR_OP_SET:   return old | src;
        rv_isa_pkg::CSR_OP_CLEAR: return old & ~src;
        default: return '0;
    endcase
endfunction

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);  // Right-shift Galois form
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

`endif

// File: sim/tb_decode_stage.sv
`default_nettype none

module tb_decode_stage;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int XLEN          = rv_isa_pkg::XLEN;
    localparam int RESET_TIMEOUT = 20;
    localparam int WATCHDOG_NS   = 20000;

    logic                                clk;
    logic                                rst;
    logic [XLEN-1:0]                     inst;
    logic [XLEN-1:0]                     srd;
    logic                                gpr_w_en;
    logic                                is_csri;
    logic [XLEN-1:0]                     pc;
    logic [XLEN-1:0]                     intr_code;
    logic                                is_intr;
    logic                                csr_w_en;
    rv_isa_pkg::inst_type_t              inst_type;
    logic [XLEN-1:0]                     imm;
    logic [rv_isa_pkg::OPCODE_WIDTH-1:0] opcode;
    logic [rv_isa_pkg::FUNCT3_WIDTH-1:0] funct3;
    logic [rv_isa_pkg::FUNCT7_WIDTH-1:0] funct7;
    logic [XLEN-1:0]                     src1;
    logic [XLEN-1:0]                     src2;
    logic [XLEN-1:0]                     mepc;
    logic [XLEN-1:0]                     mtvec;
    logic [XLEN-1:0]                     csr_r;

    logic [31:0]     lfsr_state;
    logic [XLEN-1:0] gpr_model [32];
    logic [XLEN-1:0] mstatus_m;
    logic [XLEN-1:0] mtvec_m;
    logic [XLEN-1:0] mepc_m;
    logic [XLEN-1:0] mcause_m;
    int              errors;
    int              checks;
    int              tests_run;
    int              tests_failed;

    `include "tb_decode_model.svh"

    decode_stage #(
        .NR_REGS(32)
    ) dut_i (
        .clk      (clk),
        .rst      (rst),
        .inst     (inst),
        .inst_type(inst_type),
        .imm      (imm),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7   (funct7),
        .srd      (srd),
        .src1     (src1),
        .src2     (src2),
        .gpr_w_en (gpr_w_en),
        .is_csri  (is_csri),
        .pc       (pc),
        .mepc     (mepc),
        .mtvec    (mtvec),
        .csr_r    (csr_r),
        .intr_code(intr_code),
        .is_intr  (is_intr),
        .csr_w_en (csr_w_en)
    );

    always #2 clk = ~clk;

    function automatic logic [XLEN-1:0] csr_model_read(input logic [11:0] addr);
        case (addr)
            rv_csr_pkg::CSR_MSTATUS: return mstatus_m;
            rv_csr_pkg::CSR_MTVEC:   return mtvec_m;
            rv_csr_pkg::CSR_MEPC:    return mepc_m;
            rv_csr_pkg::CSR_MCAUSE:  return mcause_m;
            default:                 return '0;
        endcase
    endfunction

    function automatic void csr_model_write(input logic [11:0] addr, input logic [XLEN-1:0] v);
        case (addr)
            rv_csr_pkg::CSR_MSTATUS: mstatus_m = v;
            rv_csr_pkg::CSR_MTVEC:   mtvec_m = v;
            rv_csr_pkg::CSR_MEPC:    mepc_m = v;
            rv_csr_pkg::CSR_MCAUSE:  mcause_m = v;
            default:                 ;  // Unknown CSR keeps everything
        endcase
    endfunction

    task automatic check_type(input string name, input rv_isa_pkg::inst_type_t exp,
                              input rv_isa_pkg::inst_type_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        tests_run++;
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errors - errors_at_start);
        end else begin
            $display("Test %s passed", name);
        end
    endtask

    task automatic apply_inst(input logic [XLEN-1:0] word);
        @(posedge clk);
        inst <= word;
        @(negedge clk);  // Decode outputs are settled mid-cycle
    endtask

    // Strobe a write to rd, then read rd back on both ports the next cycle
    task automatic write_then_read(input logic [4:0] rd, input logic [XLEN-1:0] data);
        @(posedge clk);
        inst <= {7'd0, 5'd0, 5'd0, 3'd0, rd, rv_isa_pkg::OP_REG};
        srd <= data;
        gpr_w_en <= 1'b1;
        @(posedge clk);
        gpr_w_en <= 1'b0;
        inst <= {7'd0, rd, rd, 3'd0, 5'd0, rv_isa_pkg::OP_REG};
        @(negedge clk);
        if (rd != 5'd0) begin
            gpr_model[rd] = data;
        end
        check_word($sformatf("src1[x%0d]", rd), gpr_model[rd], src1);
        check_word($sformatf("src2[x%0d]", rd), gpr_model[rd], src2);
    endtask

    task automatic csr_step(input logic [11:0] addr, input logic [2:0] f3,
                            input logic [4:0] field, input logic csri);
        logic [XLEN-1:0] src;
        logic [XLEN-1:0] next;
        src  = csri ? {27'd0, field} : gpr_model[field];
        next = model_csr(csr_model_read(addr), src, rv_isa_pkg::csr_op_t'(f3[1:0]));
        @(posedge clk);
        inst <= {addr, field, f3, 5'd0, rv_isa_pkg::OP_SYSTEM};
        is_csri <= csri;
        csr_w_en <= 1'b1;
        @(posedge clk);
        csr_w_en <= 1'b0;
        @(negedge clk);
        csr_model_write(addr, next);
        check_word($sformatf("csr_r[%h]", addr), csr_model_read(addr), csr_r);
        check_word("mtvec", mtvec_m, mtvec);
        check_word("mepc", mepc_m, mepc);
    endtask

    task automatic trap_step(input logic [11:0] w_addr, input logic with_write);
        logic [XLEN-1:0] trap_pc;
        logic [XLEN-1:0] code;
        trap_pc = take_bits(30) << 2;
        code    = take_bits(32);
        @(posedge clk);
        pc <= trap_pc;
        intr_code <= code;
        is_intr <= 1'b1;
        if (with_write) begin
            inst <= {w_addr, 5'd5, 3'b001, 5'd0, rv_isa_pkg::OP_SYSTEM};  // CSRRW from x5
            is_csri <= 1'b0;
            csr_w_en <= 1'b1;
        end
        @(posedge clk);
        is_intr <= 1'b0;
        csr_w_en <= 1'b0;
        inst <= {rv_csr_pkg::CSR_MCAUSE, 5'd0, 3'b010, 5'd0, rv_isa_pkg::OP_SYSTEM};
        @(negedge clk);
        if (with_write) begin
            csr_model_write(w_addr, gpr_model[5]);
        end
        mepc_m   = trap_pc;  // Trap entry overrides any write to mepc or mcause
        mcause_m = code;
        check_word("mepc", mepc_m, mepc);
        check_word("csr_r[mcause]", mcause_m, csr_r);
        check_word("mtvec", mtvec_m, mtvec);
    endtask

    task automatic test_reset_values();
        int              start;
        logic [XLEN-1:0] word;
        logic [11:0]     addrs [4];
        start = errors;
        addrs = '{rv_csr_pkg::CSR_MSTATUS, rv_csr_pkg::CSR_MTVEC,
                  rv_csr_pkg::CSR_MEPC, rv_csr_pkg::CSR_MCAUSE};
        for (int i = 0; i < 4; i++) begin
            word = take_bits(32);
            word[6:0] = rv_isa_pkg::OP_REG;
            apply_inst(word);
            check_word("src1", '0, src1);
            check_word("src2", '0, src2);
        end
        for (int i = 0; i < 4; i++) begin
            apply_inst({addrs[i], 5'd0, 3'b010, 5'd0, rv_isa_pkg::OP_SYSTEM});
            check_word($sformatf("csr_r[%h]", addrs[i]), csr_model_read(addrs[i]), csr_r);
        end
        check_word("mepc", '0, mepc);
        check_word("mtvec", '0, mtvec);
        finish_test("reset_values", start);
    endtask

    task automatic test_decode();
        int              start;
        logic [24:0]     upper;
        logic [XLEN-1:0] word;
        logic [6:0]      ops [11];
        start = errors;
        ops = '{rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC, rv_isa_pkg::OP_JAL,
                rv_isa_pkg::OP_JALR, rv_isa_pkg::OP_BRANCH, rv_isa_pkg::OP_LOAD,
                rv_isa_pkg::OP_STORE, rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_REG,
                rv_isa_pkg::OP_SYSTEM, 7'b0001111};  // Last one is FENCE, not decoded here
        for (int i = 0; i < 11; i++) begin
            for (int k = 0; k < 3; k++) begin
                upper = take_bits(25);
                word  = {upper, ops[i]};
                apply_inst(word);
                check_type("inst_type", model_type(ops[i]), inst_type);
                check_word("imm", model_imm(word, model_type(ops[i])), imm);
                check_word("opcode", 32'(word[6:0]), 32'(opcode));
                check_word("funct3", 32'(word[14:12]), 32'(funct3));
                check_word("funct7", 32'(word[31:25]), 32'(funct7));
            end
        end
        finish_test("decode", start);
    endtask

    task automatic test_gpr();
        int start;
        start = errors;
        for (int i = 0; i < 8; i++) begin
            write_then_read(5'(take_bits(5)), take_bits(32));
        end
        write_then_read(5'd0, take_bits(32));
        finish_test("gpr", start);
    endtask

    task automatic test_csr();
        int          start;
        logic [11:0] targets [2];
        logic [11:0] all_csrs [4];
        start = errors;
        targets  = '{rv_csr_pkg::CSR_MTVEC, rv_csr_pkg::CSR_MEPC};
        all_csrs = '{rv_csr_pkg::CSR_MSTATUS, rv_csr_pkg::CSR_MTVEC,
                     rv_csr_pkg::CSR_MEPC, rv_csr_pkg::CSR_MCAUSE};
        write_then_read(5'd5, take_bits(32));
        write_then_read(5'd7, take_bits(32));
        for (int t = 0; t < 2; t++) begin
            for (int op = 1; op < 4; op++) begin
                csr_step(targets[t], 3'(op), (op == 2) ? 5'd7 : 5'd5, 1'b0);
                csr_step(targets[t], 3'(op) | 3'b100, 5'(take_bits(5)), 1'b1);
            end
        end
        csr_step(12'h7c0, 3'b001, 5'd5, 1'b0);
        for (int t = 0; t < 4; t++) begin
            apply_inst({all_csrs[t], 5'd0, 3'b010, 5'd0, rv_isa_pkg::OP_SYSTEM});
            check_word($sformatf("csr_r[%h]", all_csrs[t]), csr_model_read(all_csrs[t]),
                       csr_r);
        end
        finish_test("csr", start);
    endtask

    task automatic test_trap();
        int start;
        start = errors;
        trap_step(rv_csr_pkg::CSR_MEPC, 1'b0);
        trap_step(rv_csr_pkg::CSR_MEPC, 1'b1);
        trap_step(rv_csr_pkg::CSR_MTVEC, 1'b1);
        finish_test("trap", start);
    endtask

    initial begin
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation ran past its time limit");
        $display("Finished with errors");
        $finish;
    end

    initial begin : main_flow
        int cycles;
        clk       = 1'b0;
        rst       = 1'b1;
        inst      = '0;
        srd       = '0;
        gpr_w_en  = 1'b0;
        is_csri   = 1'b0;
        pc        = '0;
        intr_code = '0;
        is_intr   = 1'b0;
        csr_w_en  = 1'b0;
        lfsr_state   = 32'h713f_2dd8;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 32; i++) begin
            gpr_model[i] = '0;
        end
        mstatus_m = rv_csr_pkg::MSTATUS_RESET;
        mtvec_m   = '0;
        mepc_m    = '0;
        mcause_m  = '0;
        cycles = 0;
        while (rst !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            $display("Reset was not released in time");
            $display("Finished with errors");
            $finish;
        end else begin
            test_reset_values();
            test_decode();
            test_gpr();
            test_csr();
            test_trap();
            $display("Tests run %0d, failed %0d; checks %0d, errors %0d",
                     tests_run, tests_failed, checks, errors);
            if (errors == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+sim
rtl/rv_isa_pkg.sv
rtl/rv_csr_pkg.sv
rtl/key_lut.sv
rtl/gpr_file.sv
rtl/csr_file.sv
rtl/decode_stage.sv
sim/tb_decode_stage.sv
